// File: build.f
+incdir+dv
source/tile_port_pkg.sv
source/tile_grant_fsm.sv
source/tile_access_timer.sv
source/tile_line_ram.sv
source/tile_port_top.sv
dv/tile_port_tb.sv

// File: Bender.yml
package:
  name: tile_port

sources:
  # RTL in compile order
  - files:
      - source/tile_port_pkg.sv
      - source/tile_grant_fsm.sv
      - source/tile_access_timer.sv
      - source/tile_line_ram.sv
      - source/tile_port_top.sv

  # Testbench, top module tile_port_tb
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tile_port_tb.sv

// File: dv/tile_port_checks.svh
// Tile port testbench checks: result counters and typed compare tasks
`ifndef TILE_PORT_CHECKS_SVH
`define TILE_PORT_CHECKS_SVH

// ========================================
// Counters
// ========================================

// Comparisons made so far
int check_count = 0;
// Failures of any kind, timeouts included
int error_count = 0;

// Failure with no value pair to show, described in words
task automatic note_error(input string what);
    error_count++;
    $display("Error at %0t: %s", $time, what);
endtask

// ========================================
// Compare tasks
// ========================================

// Acked core against the predicted winner
task automatic check_core(input string name, input core_id_t got, input core_id_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

// Read line against the expected copy
// Full 512-bit values in hex on mismatch
task automatic check_line(input string name, input tile_line_t got, input tile_line_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

`endif

// File: dv/tile_port_tb.sv
// Tile port A testbench: round-robin order, fixed latency and read data
module tile_port_tb
    import tile_port_pkg::*;
();

    // Input drive offset after the rising edge
    localparam int DRIVE_DELAY = 1;
    // Cycles a request may wait for its ack
    localparam int ACK_TIMEOUT = 200;

    logic                 sys_clk;
    logic                 sys_rst_n;
    tile_req_t            core_req [NUM_CORES];
    logic [NUM_CORES-1:0] core_ack;
    tile_line_t           rdata;

    `include "tile_port_checks.svh"

    // Reference model state
    tile_line_t shadow_mem [LINE_COUNT];
    logic       shadow_valid [LINE_COUNT];
    core_id_t   shadow_last;
    logic       model_busy;
    int         model_count;
    core_id_t   model_grant;
    tile_req_t  model_snap;

    // Acked cores in order of service, cleared per test
    core_id_t ack_log [$];
    int       tests_run = 0;

    tile_port_top uut (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .core_req  (core_req),
        .core_ack  (core_ack),
        .rdata     (rdata)
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    // ========================================
    // Reference model
    // ========================================

    // Scan from last + 1 with wrap, last itself checked at the end
    function automatic core_id_t predict_winner(input logic [NUM_CORES-1:0] pending,
                                                input core_id_t last);
        core_id_t cand;
        core_id_t win;
        logic     found;
        win   = last;
        found = 1'b0;
        for (int off = 1; off <= NUM_CORES; off++) begin
            cand = core_id_t'((int'(last) + off) % NUM_CORES);
            if (!found && pending[cand]) begin
                win   = cand;
                found = 1'b1;
            end
        end
        return win;
    endfunction

    function automatic core_id_t ack_to_core(input logic [NUM_CORES-1:0] ack);
        core_id_t id;
        id = '0;
        for (int c = 0; c < NUM_CORES; c++) begin
            if (ack[c]) begin
                id = core_id_t'(c);
            end
        end
        return id;
    endfunction

    function automatic tile_line_t random_line();
        tile_line_t line;
        for (int w = 0; w < LINE_BITS / 32; w++) begin
            line[w*32 +: 32] = $urandom;
        end
        return line;
    endfunction

    // Compare process, mid-cycle where inputs and outputs are settled
    // Idle cycle with any req: grant at the closing edge
    // Busy: ack expected in the ACCESS_CYCLES-th cycle only
    always @(negedge sys_clk) begin
        logic [NUM_CORES-1:0] pending;
        if (!sys_rst_n) begin
            shadow_last = '0;
            model_busy  = 1'b0;
            model_count = 0;
        end else if (model_busy) begin
            model_count++;
            if (model_count == ACCESS_CYCLES) begin
                if (core_ack == '0) begin
                    note_error($sformatf("no ack for core %0d in its last cycle", model_grant));
                end else if (!$onehot(core_ack)) begin
                    note_error("more than one ack bit high");
                end else begin
                    check_core("core_ack", ack_to_core(core_ack), model_grant);
                    // Read returns the line as it was before this access
                    if (!model_snap.wen && shadow_valid[model_snap.addr]) begin
                        check_line("rdata", rdata, shadow_mem[model_snap.addr]);
                    end
                end
                if (model_snap.wen) begin
                    shadow_mem[model_snap.addr]   = model_snap.wdata;
                    shadow_valid[model_snap.addr] = 1'b1;
                end
                shadow_last = model_grant;
                model_busy  = 1'b0;
            end else if (core_ack != '0) begin
                note_error("ack arrived before the access latency ran out");
            end
        end else begin
            if (core_ack != '0) begin
                note_error("ack while the port was idle");
            end
            for (int c = 0; c < NUM_CORES; c++) begin
                pending[c] = core_req[c].req;
            end
            if (pending != '0) begin
                model_grant = predict_winner(pending, shadow_last);
                model_snap  = core_req[model_grant];
                model_busy  = 1'b1;
                model_count = 0;
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    // One request from one core, held until its ack or the timeout
    // With keep_req the next request follows the ack with req left high
    // Returns read data seen in the ack cycle and the cycles waited
    task automatic do_request(input int c, input logic wen, input line_index_t addr,
                              input tile_line_t wdata, input logic keep_req,
                              output tile_line_t rd, output int waited);
        logic got;
        // A request still up means the ack edge has just passed
        if (!core_req[c].req) begin
            @(posedge sys_clk);
            #DRIVE_DELAY;
        end
        core_req[c].req   = 1'b1;
        core_req[c].wen   = wen;
        core_req[c].addr  = addr;
        core_req[c].wdata = wdata;
        got    = 1'b0;
        waited = 0;
        rd     = '0;
        while (!got && waited < ACK_TIMEOUT) begin
            @(negedge sys_clk);
            waited++;
            if (core_ack[c]) begin
                got = 1'b1;
                rd  = rdata;
            end
        end
        if (!got) begin
            note_error($sformatf("core %0d: ack never came in %0d cycles", c, ACK_TIMEOUT));
        end else begin
            ack_log.push_back(core_id_t'(c));
        end
        @(posedge sys_clk);
        #DRIVE_DELAY;
        if (!keep_req || !got) begin
            core_req[c].req = 1'b0;
            // Ack is a single-cycle pulse
            @(negedge sys_clk);
            if (got && core_ack[c]) begin
                note_error($sformatf("ack to core %0d lasted more than one cycle", c));
            end
        end
    endtask

    // Back-to-back requests with req held across each ack, alternating read and write
    task automatic stream_requests(input int c, input int n);
        tile_line_t rd;
        int         waited;
        for (int i = 0; i < n; i++) begin
            do_request(c, logic'(i % 2), line_index_t'($urandom_range(0, 7)),
                       random_line(), logic'(i < n - 1), rd, waited);
        end
    endtask

    // Random reads and writes with idle gaps, small address range for hits
    task automatic random_traffic(input int c, input int n);
        tile_line_t rd;
        int         waited;
        int         gap;
        for (int i = 0; i < n; i++) begin
            gap = $urandom_range(0, 5);
            repeat (gap) @(posedge sys_clk);
            do_request(c, logic'($urandom_range(0, 1)), line_index_t'($urandom_range(0, 15)),
                       random_line(), 1'b0, rd, waited);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("[%0t] %s: passed", $time, name);
        end else begin
            $display("[%0t] %s: %0d errors", $time, name, error_count - errs_before);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        tile_line_t line_a;
        tile_line_t rd;
        int         waited;
        int         errs;
        core_id_t   exp_order [NUM_CORES];
        void'($urandom(37359));
        sys_rst_n = 1'b0;
        for (int c = 0; c < NUM_CORES; c++) begin
            core_req[c] = '0;
        end
        for (int l = 0; l < LINE_COUNT; l++) begin
            shadow_valid[l] = 1'b0;
        end
        repeat (16) @(posedge sys_clk);
        #DRIVE_DELAY;
        sys_rst_n = 1'b1;

        // All four at once while last_grant still holds core 0
        errs = error_count;
        ack_log.delete();
        exp_order = '{core_id_t'(1), core_id_t'(2), core_id_t'(3), core_id_t'(0)};
        fork
            do_request(0, 1'b1, 6'd0, random_line(), 1'b0, rd, waited);
            do_request(1, 1'b1, 6'd1, random_line(), 1'b0, rd, waited);
            do_request(2, 1'b1, 6'd2, random_line(), 1'b0, rd, waited);
            do_request(3, 1'b1, 6'd3, random_line(), 1'b0, rd, waited);
        join
        if (ack_log.size() != NUM_CORES) begin
            note_error($sformatf("expected %0d acks, saw %0d", NUM_CORES, ack_log.size()));
        end else begin
            for (int i = 0; i < NUM_CORES; i++) begin
                check_core("ack order", ack_log[i], exp_order[i]);
            end
        end
        end_test("simultaneous requests after reset", errs);

        // Write by core 2, read back by core 0
        errs   = error_count;
        line_a = random_line();
        do_request(2, 1'b1, 6'd9, line_a, 1'b0, rd, waited);
        do_request(0, 1'b0, 6'd9, '0, 1'b0, rd, waited);
        check_line("rdata", rd, line_a);
        end_test("write then read back", errs);

        // Lone request on an idle port, one cycle before the sampling edge
        errs = error_count;
        repeat (3) @(posedge sys_clk);
        do_request(1, 1'b0, 6'd9, '0, 1'b0, rd, waited);
        check_count++;
        if (waited != ACCESS_CYCLES + 1) begin
            error_count++;
            $display("Fail at %0t: core_ack latency got %0d expected %0d",
                     $time, waited, ACCESS_CYCLES + 1);
        end
        end_test("lone request latency", errs);

        // Two cores contending, service alternates
        errs = error_count;
        ack_log.delete();
        fork
            stream_requests(0, 6);
            stream_requests(3, 6);
        join
        if (ack_log.size() != 12) begin
            note_error($sformatf("expected 12 acks, saw %0d", ack_log.size()));
        end
        for (int i = 1; i < ack_log.size(); i++) begin
            check_core("ack alternation", ack_log[i],
                       (ack_log[i-1] == core_id_t'(0)) ? core_id_t'(3) : core_id_t'(0));
        end
        end_test("cores 0 and 3 alternate", errs);

        // Random mix from every core, checked by the compare process
        errs = error_count;
        fork
            random_traffic(0, 12);
            random_traffic(1, 12);
            random_traffic(2, 12);
            random_traffic(3, 12);
        join
        end_test("random traffic", errs);

        repeat (4) @(posedge sys_clk);
        $display("tests=%0d checks=%0d errors=%0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: source/tile_port_top.sv
// Tile port A top level, joins the grant FSM, access timer and line RAM
module tile_port_top
    import tile_port_pkg::*;
(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  tile_req_t            core_req [NUM_CORES],
    output logic [NUM_CORES-1:0] core_ack,
    output tile_line_t           rdata
);

    // ========================================
    // Internal port A wiring
    // ========================================

    // Winning request, already muxed
    tile_req_t grant_req;
    // High from grant through the ack cycle
    logic      busy;
    // Last cycle of the fixed-latency access
    logic      access_done;

    // Arbiter: picks one engine, steers the ack back
    tile_grant_fsm u_grant_fsm (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .core_req    (core_req),
        .access_done (access_done),
        .grant_req   (grant_req),
        .busy        (busy),
        .core_ack    (core_ack)
    );

    // Paces each grant to ACCESS_CYCLES
    tile_access_timer u_access_timer (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .busy        (busy),
        .access_done (access_done)
    );

    // Shared line storage
    // rdata fans out to every core, valid for the acked one only
    tile_line_ram u_line_ram (
        .sys_clk     (sys_clk),
        .grant_req   (grant_req),
        .busy        (busy),
        .access_done (access_done),
        .rdata       (rdata)
    );

endmodule

// File: source/tile_line_ram.sv
// Shared tile line RAM, reads the granted line and writes on completion
module tile_line_ram
    import tile_port_pkg::*;
(
    input  logic       sys_clk,
    input  tile_req_t  grant_req,
    input  logic       busy,
    input  logic       access_done,
    output tile_line_t rdata
);

    // ========================================
    // Storage
    // ========================================

    // LINE_COUNT lines of LINE_BITS each
    tile_line_t mem [LINE_COUNT];

    // Write strobe for the granted access
    logic wr_en;

    // Commit happens at the edge that ends the ack cycle
    assign wr_en = access_done && grant_req.req && grant_req.wen;

    // ========================================
    // Write port
    // ========================================

    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[grant_req.addr] <= grant_req.wdata;
        end
    end

    // ========================================
    // Read port
    // ========================================

    // Sample the addressed line on every busy cycle
    // The write lands at the end of the ack cycle, so rdata in the ack
    // cycle still shows the line as it was before this access
    // Holds its last value while idle
    always_ff @(posedge sys_clk) begin
        if (busy) begin
            rdata <= mem[grant_req.addr];
        end
    end

    // ========================================
    // Checks
    // ========================================

    // Write intent and payload must not move under an open grant
    a_write_stable_while_busy: assert property (
        @(posedge sys_clk)
        busy |=> (!busy || ($stable(grant_req.wen) && $stable(grant_req.wdata)))
    );

endmodule

// File: source/tile_access_timer.sv
// Fixed-latency access timer, pulses completion on the last busy cycle
module tile_access_timer
    import tile_port_pkg::*;
(
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic busy,
    output logic access_done
);

    // Busy cycles already spent on the current grant
    logic [ACCESS_COUNT_BITS-1:0] count;

    // Number of the current busy cycle, one up to ACCESS_CYCLES
    logic [ACCESS_COUNT_BITS-1:0] cycle_num;

    assign cycle_num = count + ACCESS_COUNT_BITS'(1);

    // ========================================
    // Completion
    // ========================================

    // High during the ACCESS_CYCLES-th busy cycle only
    assign access_done = busy && (cycle_num == ACCESS_COUNT_BITS'(ACCESS_CYCLES));

    // ========================================
    // Cycle counter
    // ========================================

    // Advance while busy
    // Back to zero after completion or whenever the port is idle
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            count <= '0;
        end else if (!busy || access_done) begin
            count <= '0;
        end else begin
            count <= cycle_num;
        end
    end

    // Completion must end the grant, which also keeps pulses apart
    a_done_single_pulse: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        access_done |=> !busy
    );

endmodule

// File: source/tile_grant_fsm.sv
// Round-robin grant FSM for tile port A, selects the winner and routes its ack
module tile_grant_fsm
    import tile_port_pkg::*;
(
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,
    input  tile_req_t            core_req [NUM_CORES],
    input  logic                 access_done,
    output tile_req_t            grant_req,
    output logic                 busy,
    output logic [NUM_CORES-1:0] core_ack
);

    // ========================================
    // State
    // ========================================

    // Core that owns the port while busy
    core_id_t grant;
    // Core served most recently, anchors the rotation
    core_id_t last_grant;

    // Scan results
    core_id_t next_grant;
    logic     any_req;

    // ========================================
    // Rotating priority scan
    // ========================================

    // Start at last_grant + 1 and wrap around
    // Offset NUM_CORES wraps back to last_grant, so it is checked last
    // First requester found wins
    always_comb begin
        core_id_t cand;
        cand       = last_grant;
        next_grant = last_grant;
        any_req    = 1'b0;
        for (int i = 1; i <= NUM_CORES; i++) begin
            cand = last_grant + core_id_t'(i);
            if (!any_req && core_req[cand].req) begin
                next_grant = cand;
                any_req    = 1'b1;
            end
        end
    end

    // ========================================
    // Idle / busy control
    // ========================================

    // Idle: grant at the first edge that sees any req
    // Busy: hold the grant until the timer reports completion
    // Completion drops busy, so at least one idle cycle follows
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            grant      <= '0;
            last_grant <= '0;
            busy       <= 1'b0;
        end else if (busy) begin
            if (access_done) begin
                busy       <= 1'b0;
                last_grant <= grant;
            end
        end else if (any_req) begin
            grant <= next_grant;
            busy  <= 1'b1;
        end
    end

    // ========================================
    // Request mux and ack steering
    // ========================================

    // Granted core's request onto the shared port
    // req is qualified by busy so an idle port presents no request
    always_comb begin
        grant_req     = core_req[grant];
        grant_req.req = busy && core_req[grant].req;
    end

    // Completion pulse goes to the granted core only
    always_comb begin
        for (int c = 0; c < NUM_CORES; c++) begin
            core_ack[c] = access_done && (grant == core_id_t'(c));
        end
    end

    // ========================================
    // Checks
    // ========================================

    // Timer must only complete an access that is in flight
    a_done_only_when_busy: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        access_done |-> busy
    );

    // Timer completion is a single pulse, so each ack lasts one cycle
    a_ack_single_cycle: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        (core_ack != '0) |=> (core_ack == '0)
    );

    // Winner keeps its request up through the ack cycle
    a_req_held_until_ack: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        busy |-> core_req[grant].req
    );

endmodule

// File: source/tile_port_pkg.sv
// Tile port package: shared widths, counts and the per-core request struct
package tile_port_pkg;

    // ========================================
    // Core count and indexing
    // ========================================

    // Tile engines sharing port A
    localparam int NUM_CORES = 4;
    // Enough bits to name any core
    localparam int CORE_ID_BITS = 2;

    // ========================================
    // Line geometry
    // ========================================

    // One tile line is a full 512-bit row
    localparam int LINE_BITS = 512;
    // Line address width, sized to the RAM depth
    localparam int LINE_INDEX_BITS = 6;
    localparam int LINE_COUNT = 64;

    // ========================================
    // Access pacing
    // ========================================

    // Busy cycles per granted access, ack on the last one
    localparam int ACCESS_CYCLES = 4;
    // Must hold the value ACCESS_CYCLES itself
    localparam int ACCESS_COUNT_BITS = 3;

    // Core index
    typedef logic [CORE_ID_BITS-1:0] core_id_t;

    // Raw tile line payload
    typedef logic [LINE_BITS-1:0] tile_line_t;

    // Line address into the shared RAM
    typedef logic [LINE_INDEX_BITS-1:0] line_index_t;

    // One engine's request, held at a level until its ack
    // Also used for the granted request after selection
    typedef struct packed {
        logic        req;
        logic        wen;
        line_index_t addr;
        tile_line_t  wdata;
    } tile_req_t;

endpackage
